// File: hdl/kronos_macros.svh
// Default boot address and register count for the Kronos core.
// Included by any module that needs the defaults.
`ifndef KRONOS_MACROS_SVH
`define KRONOS_MACROS_SVH

// Reset program counter, word aligned
`define KRONOS_BOOT_ADDR 32'h0

// Architectural registers, x0 included
`define KRONOS_NREGS 32

`endif

// File: hdl/kronos_types.sv
// Shared types for the Kronos core.
// Ports use scoped names and module bodies import the whole package.
package kronos_types;

  // Data, address and instruction word
  typedef logic [31:0] word_t;

  // Register index
  typedef logic [4:0] reg_sel_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU
  } alu_op_t;

  // Fetch sequencer
  typedef enum logic [1:0] {
    IF_IDLE,
    IF_REQ,
    IF_HOLD
  } if_state_t;

  // Execute memory sequencer
  typedef enum logic {
    EX_RUN,
    EX_MEM
  } ex_state_t;

endpackage

// File: hdl/kronos_rf.sv
// Integer register file with two read ports and one write port.
// A write is visible to a read of the same register in the same cycle.
`include "kronos_macros.svh"

module kronos_rf (
  input  logic                   clk,
  input  logic                   reset,
  input  kronos_types::reg_sel_t rs1_sel,
  input  kronos_types::reg_sel_t rs2_sel,
  output kronos_types::word_t    rs1_data,
  output kronos_types::word_t    rs2_data,
  input  logic                   regwr_en,
  input  kronos_types::reg_sel_t regwr_sel,
  input  kronos_types::word_t    regwr_data
);
  import kronos_types::*;

  word_t regs [`KRONOS_NREGS];
  logic  wr_live;

  // x0 never takes a write
  assign wr_live = regwr_en && (regwr_sel != '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `KRONOS_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_live) begin
      regs[regwr_sel] <= regwr_data;
    end
  end

  // Bypass the pending write
  assign rs1_data = (wr_live && regwr_sel == rs1_sel) ? regwr_data : regs[rs1_sel];
  assign rs2_data = (wr_live && regwr_sel == rs2_sel) ? regwr_data : regs[rs2_sel];

endmodule

// File: hdl/kronos_if.sv
// Fetch stage: program counter and instruction bus sequencer.
// Holds one fetched instruction until decode takes it.
`include "kronos_macros.svh"

module kronos_if #(
  parameter kronos_types::word_t BOOT_ADDR = `KRONOS_BOOT_ADDR
)(
  input  logic                clk,
  input  logic                reset,
  output kronos_types::word_t instr_addr,
  output logic                instr_req,
  input  kronos_types::word_t instr_data,
  input  logic                instr_ack,
  output kronos_types::word_t fetch_instr,
  output kronos_types::word_t fetch_pc,
  output logic                fetch_vld,
  input  logic                fetch_rdy,
  input  logic                branch,
  input  kronos_types::word_t branch_target
);
  import kronos_types::*;

  if_state_t state;
  word_t     pc;
  word_t     redirect_pc;
  logic      discard;

  assign instr_addr = pc;
  assign instr_req  = (state == IF_REQ);
  assign fetch_pc   = pc;
  assign fetch_vld  = (state == IF_HOLD);

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= IF_IDLE;
      pc      <= BOOT_ADDR;
      discard <= 1'b0;
    end else begin
      case (state)
        IF_IDLE: state <= IF_REQ;
        IF_REQ: begin
          if (instr_ack) begin
            // Stale data is dropped and the redirect is requested
            if (branch) pc <= branch_target;
            else if (discard) pc <= redirect_pc;
            else state <= IF_HOLD;
            discard <= 1'b0;
          end else if (branch) begin
            // Request in flight, wait for its ack first
            discard <= 1'b1;
          end
        end
        IF_HOLD: begin
          if (branch) begin
            pc    <= branch_target;
            state <= IF_REQ;
          end else if (fetch_rdy) begin
            pc    <= pc + 32'd4;
            state <= IF_REQ;
          end
        end
        default: state <= IF_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (branch) redirect_pc <= branch_target;
    if (instr_req && instr_ack) fetch_instr <= instr_data;
  end

endmodule

// File: hdl/kronos_id.sv
// Decode stage: field decode, immediates, operand read and hazard stall.
// Registers one decoded instruction for execute.
module kronos_id (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    flush,
  input  kronos_types::word_t     fetch_instr,
  input  kronos_types::word_t     fetch_pc,
  input  logic                    fetch_vld,
  output logic                    fetch_rdy,
  output kronos_types::reg_sel_t  rs1_sel,
  output kronos_types::reg_sel_t  rs2_sel,
  input  kronos_types::word_t     rs1_data,
  input  kronos_types::word_t     rs2_data,
  input  logic                    ex_busy,
  input  kronos_types::reg_sel_t  ex_busy_rd,
  output kronos_types::word_t     decode_pc,
  output kronos_types::word_t     decode_op1,
  output kronos_types::word_t     decode_op2,
  output kronos_types::word_t     decode_imm,
  output kronos_types::alu_op_t   decode_alu_op,
  output kronos_types::reg_sel_t  decode_rd,
  output logic                    decode_is_load,
  output logic                    decode_is_store,
  output logic                    decode_is_branch,
  output logic                    decode_is_jal,
  output logic                    decode_is_jalr,
  output logic                    decode_wr_en,
  output logic [2:0]              decode_funct3,
  output logic                    decode_vld,
  input  logic                    decode_rdy
);
  import kronos_types::*;

  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_REG    = 7'b0110011;

  logic [6:0] opcode;
  logic [2:0] funct3;
  reg_sel_t   rd;
  word_t      imm_i, imm_s, imm_b, imm_u, imm_j;
  word_t      imm, op1;
  alu_op_t    alu_op;
  logic       use_rs2, is_load, is_store, is_branch, is_jal, is_jalr, wr_en;
  logic       hazard, take;

  function automatic alu_op_t alu_decode(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  assign opcode  = fetch_instr[6:0];
  assign funct3  = fetch_instr[14:12];
  assign rd      = fetch_instr[11:7];
  assign rs1_sel = fetch_instr[19:15];
  assign rs2_sel = fetch_instr[24:20];

  // ====================
  // Immediates
  // ====================
  assign imm_i = {{20{fetch_instr[31]}}, fetch_instr[31:20]};
  assign imm_s = {{20{fetch_instr[31]}}, fetch_instr[31:25], fetch_instr[11:7]};
  assign imm_b = {{19{fetch_instr[31]}}, fetch_instr[31], fetch_instr[7],
                  fetch_instr[30:25], fetch_instr[11:8], 1'b0};
  assign imm_u = {fetch_instr[31:12], 12'b0};
  assign imm_j = {{11{fetch_instr[31]}}, fetch_instr[31], fetch_instr[19:12],
                  fetch_instr[20], fetch_instr[30:21], 1'b0};

  always_comb begin
    imm       = imm_i;
    op1       = rs1_data;
    alu_op    = ALU_ADD;
    use_rs2   = 1'b0;
    is_load   = 1'b0;
    is_store  = 1'b0;
    is_branch = 1'b0;
    is_jal    = 1'b0;
    is_jalr   = 1'b0;
    wr_en     = 1'b0;
    case (opcode)
      OP_LUI: begin
        imm   = imm_u;
        op1   = '0;
        wr_en = 1'b1;
      end
      OP_AUIPC: begin
        imm   = imm_u;
        op1   = fetch_pc;
        wr_en = 1'b1;
      end
      OP_JAL: begin
        imm    = imm_j;
        is_jal = 1'b1;
        wr_en  = 1'b1;
      end
      OP_JALR: begin
        is_jalr = 1'b1;
        wr_en   = 1'b1;
      end
      OP_BRANCH: begin
        imm       = imm_b;
        use_rs2   = 1'b1;
        is_branch = 1'b1;
      end
      OP_LOAD: begin
        is_load = 1'b1;
        wr_en   = 1'b1;
      end
      OP_STORE: begin
        imm      = imm_s;
        use_rs2  = 1'b1;
        is_store = 1'b1;
      end
      OP_IMM: begin
        // Only shifts read bit 30 here, there is no SUBI
        alu_op = alu_decode(funct3, funct3 == 3'b101 && fetch_instr[30]);
        wr_en  = 1'b1;
      end
      OP_REG: begin
        alu_op  = alu_decode(funct3, fetch_instr[30]);
        use_rs2 = 1'b1;
        wr_en   = 1'b1;
      end
      default: wr_en = 1'b0;
    endcase
    if (rd == '0) wr_en = 1'b0;
  end

  // ====================
  // Hazard and handshake
  // ====================
  assign hazard = ex_busy && (ex_busy_rd != '0) &&
                  (ex_busy_rd == rs1_sel || ex_busy_rd == rs2_sel);
  assign fetch_rdy = (!decode_vld || decode_rdy) && !hazard;
  assign take      = fetch_vld && fetch_rdy && !flush;

  always_ff @(posedge clk) begin
    if (reset || flush) decode_vld <= 1'b0;
    else if (take) decode_vld <= 1'b1;
    else if (decode_rdy) decode_vld <= 1'b0;
  end

  always_ff @(posedge clk) begin
    if (take) begin
      decode_pc        <= fetch_pc;
      decode_op1       <= op1;
      decode_op2       <= use_rs2 ? rs2_data : imm;
      decode_imm       <= imm;
      decode_alu_op    <= alu_op;
      decode_rd        <= rd;
      decode_is_load   <= is_load;
      decode_is_store  <= is_store;
      decode_is_branch <= is_branch;
      decode_is_jal    <= is_jal;
      decode_is_jalr   <= is_jalr;
      decode_wr_en     <= wr_en;
      decode_funct3    <= funct3;
    end
  end

endmodule

// File: hdl/kronos_ex.sv
// Execute stage: ALU, branch resolution, writeback and data bus access.
// ALU ops retire on acceptance; loads and stores wait for data_ack.
module kronos_ex (
  input  logic                   clk,
  input  logic                   reset,
  input  kronos_types::word_t    decode_pc,
  input  kronos_types::word_t    decode_op1,
  input  kronos_types::word_t    decode_op2,
  input  kronos_types::word_t    decode_imm,
  input  kronos_types::alu_op_t  decode_alu_op,
  input  kronos_types::reg_sel_t decode_rd,
  input  logic                   decode_is_load,
  input  logic                   decode_is_store,
  input  logic                   decode_is_branch,
  input  logic                   decode_is_jal,
  input  logic                   decode_is_jalr,
  input  logic                   decode_wr_en,
  input  logic [2:0]             decode_funct3,
  input  logic                   decode_vld,
  output logic                   decode_rdy,
  output logic                   ex_busy,
  output kronos_types::reg_sel_t ex_busy_rd,
  output logic                   regwr_en,
  output kronos_types::reg_sel_t regwr_sel,
  output kronos_types::word_t    regwr_data,
  output logic                   branch,
  output kronos_types::word_t    branch_target,
  output kronos_types::word_t    data_addr,
  output kronos_types::word_t    data_wr_data,
  output logic                   data_wr_en,
  output logic                   data_req,
  input  kronos_types::word_t    data_rd_data,
  input  logic                   data_ack
);
  import kronos_types::*;

  ex_state_t state;
  word_t     alu_result, addr_sum, pc_sum, link;
  logic      active, is_mem, eq, lt, ltu, cond, taken;

  // Wrong-path instruction sits here during the branch cycle
  assign active = decode_vld && !branch;
  assign is_mem = decode_is_load || decode_is_store;

  assign ex_busy    = active && decode_wr_en;
  assign ex_busy_rd = decode_rd;
  assign decode_rdy = (state == EX_MEM) ? data_ack : !(active && is_mem);

  always_comb begin
    case (decode_alu_op)
      ALU_SUB:  alu_result = decode_op1 - decode_op2;
      ALU_AND:  alu_result = decode_op1 & decode_op2;
      ALU_OR:   alu_result = decode_op1 | decode_op2;
      ALU_XOR:  alu_result = decode_op1 ^ decode_op2;
      ALU_SLL:  alu_result = decode_op1 << decode_op2[4:0];
      ALU_SRL:  alu_result = decode_op1 >> decode_op2[4:0];
      ALU_SRA:  alu_result = word_t'($signed(decode_op1) >>> decode_op2[4:0]);
      ALU_SLT:  alu_result = {31'b0, lt};
      ALU_SLTU: alu_result = {31'b0, ltu};
      default:  alu_result = decode_op1 + decode_op2;
    endcase
  end

  // ====================
  // Branch resolution
  // ====================
  assign eq  = (decode_op1 == decode_op2);
  assign lt  = ($signed(decode_op1) < $signed(decode_op2));
  assign ltu = (decode_op1 < decode_op2);

  always_comb begin
    case (decode_funct3[2:1])
      2'b00:   cond = eq;
      2'b10:   cond = lt;
      2'b11:   cond = ltu;
      default: cond = 1'b0;
    endcase
    // Odd funct3 inverts the compare, 01x is not a branch
    if (decode_funct3[2:1] != 2'b01) cond = cond ^ decode_funct3[0];
  end

  assign taken    = decode_is_jal || decode_is_jalr || (decode_is_branch && cond);
  assign addr_sum = decode_op1 + decode_imm;
  assign pc_sum   = decode_pc + decode_imm;
  assign link     = decode_pc + 32'd4;

  // ====================
  // Sequencer
  // ====================
  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= EX_RUN;
      data_req   <= 1'b0;
      data_wr_en <= 1'b0;
      regwr_en   <= 1'b0;
      branch     <= 1'b0;
    end else begin
      regwr_en <= 1'b0;
      branch   <= 1'b0;
      case (state)
        EX_RUN: begin
          if (active && is_mem) begin
            state      <= EX_MEM;
            data_req   <= 1'b1;
            data_wr_en <= decode_is_store;
          end else if (active) begin
            regwr_en <= decode_wr_en;
            branch   <= taken;
          end
        end
        EX_MEM: begin
          if (data_ack) begin
            state      <= EX_RUN;
            data_req   <= 1'b0;
            data_wr_en <= 1'b0;
            regwr_en   <= decode_is_load && decode_wr_en;
          end
        end
        default: state <= EX_RUN;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    regwr_sel     <= decode_rd;
    branch_target <= decode_is_jalr ? {addr_sum[31:1], 1'b0} : pc_sum;
    if (state == EX_MEM) begin
      regwr_data <= data_rd_data;
    end else begin
      regwr_data   <= (decode_is_jal || decode_is_jalr) ? link : alu_result;
      // Held for the whole bus transfer
      data_addr    <= addr_sum;
      data_wr_data <= decode_op2;
    end
  end

endmodule

// File: hdl/kronos_core.sv
// Top level of the three-stage Kronos core.
// Connects fetch, decode, execute and the register file to both buses.
`include "kronos_macros.svh"

module kronos_core #(
  parameter kronos_types::word_t BOOT_ADDR = `KRONOS_BOOT_ADDR
)(
  input  logic                clk,
  input  logic                reset,
  // Instruction bus
  output kronos_types::word_t instr_addr,
  output logic                instr_req,
  input  kronos_types::word_t instr_data,
  input  logic                instr_ack,
  // Data bus
  output kronos_types::word_t data_addr,
  output kronos_types::word_t data_wr_data,
  output logic                data_wr_en,
  output logic                data_req,
  input  kronos_types::word_t data_rd_data,
  input  logic                data_ack
);
  import kronos_types::*;

  word_t    fetch_instr, fetch_pc;
  logic     fetch_vld, fetch_rdy;
  reg_sel_t rs1_sel, rs2_sel;
  word_t    rs1_data, rs2_data;
  word_t    decode_pc, decode_op1, decode_op2, decode_imm;
  alu_op_t  decode_alu_op;
  reg_sel_t decode_rd;
  logic     decode_is_load, decode_is_store, decode_is_branch;
  logic     decode_is_jal, decode_is_jalr, decode_wr_en;
  logic [2:0] decode_funct3;
  logic     decode_vld, decode_rdy;
  logic     ex_busy;
  reg_sel_t ex_busy_rd;
  logic     regwr_en;
  reg_sel_t regwr_sel;
  word_t    regwr_data;
  logic     branch;
  word_t    branch_target;

  // ====================
  // Fetch
  // ====================
  kronos_if #(
    .BOOT_ADDR(BOOT_ADDR)
  ) u_if (
    .clk, .reset,
    .instr_addr, .instr_req, .instr_data, .instr_ack,
    .fetch_instr, .fetch_pc, .fetch_vld, .fetch_rdy,
    .branch, .branch_target
  );

  // ====================
  // Decode
  // ====================
  // The branch pulse doubles as the pipeline flush
  kronos_id u_id (
    .clk, .reset,
    .flush (branch),
    .fetch_instr, .fetch_pc, .fetch_vld, .fetch_rdy,
    .rs1_sel, .rs2_sel, .rs1_data, .rs2_data,
    .ex_busy, .ex_busy_rd,
    .decode_pc, .decode_op1, .decode_op2, .decode_imm,
    .decode_alu_op, .decode_rd,
    .decode_is_load, .decode_is_store, .decode_is_branch,
    .decode_is_jal, .decode_is_jalr, .decode_wr_en, .decode_funct3,
    .decode_vld, .decode_rdy
  );

  // ====================
  // Execute
  // ====================
  kronos_ex u_ex (
    .clk, .reset,
    .decode_pc, .decode_op1, .decode_op2, .decode_imm,
    .decode_alu_op, .decode_rd,
    .decode_is_load, .decode_is_store, .decode_is_branch,
    .decode_is_jal, .decode_is_jalr, .decode_wr_en, .decode_funct3,
    .decode_vld, .decode_rdy,
    .ex_busy, .ex_busy_rd,
    .regwr_en, .regwr_sel, .regwr_data,
    .branch, .branch_target,
    .data_addr, .data_wr_data, .data_wr_en, .data_req,
    .data_rd_data, .data_ack
  );

  kronos_rf u_rf (
    .clk, .reset,
    .rs1_sel, .rs2_sel, .rs1_data, .rs2_data,
    .regwr_en, .regwr_sel, .regwr_data
  );

endmodule

// File: sim/kronos_mem_model.sv
// Instruction and data memory for the core testbench.
// Acks each bus request after 0 to 3 cycles and records every store in order.
module kronos_mem_model (
  input  logic                clk,
  input  logic                reset,
  input  logic                rand_delay,
  input  kronos_types::word_t instr_addr,
  input  logic                instr_req,
  output kronos_types::word_t instr_data,
  output logic                instr_ack,
  input  kronos_types::word_t data_addr,
  input  kronos_types::word_t data_wr_data,
  input  logic                data_wr_en,
  input  logic                data_req,
  output kronos_types::word_t data_rd_data,
  output logic                data_ack
);
  timeunit 1ns;
  timeprecision 1ps;
  import kronos_types::*;

  localparam int WORDS      = 256;
  localparam int MAX_STORES = 64;

  word_t       words [WORDS];
  word_t       store_addr [MAX_STORES];
  word_t       store_data [MAX_STORES];
  int          store_count;
  int unsigned seed;
  int unsigned instr_wait;
  int unsigned data_wait;

  function automatic int unsigned next_delay();
    if (rand_delay) return $urandom % 4;
    return 0;
  endfunction

  // Low two bits stay zero, so no fill word decodes as a real opcode
  task automatic fill_pattern();
    for (int i = 0; i < WORDS; i++) begin
      words[i] = 32'ha5a5_0000 ^ (i * 4);
    end
  endtask

  task automatic write_word(input word_t addr, input word_t value);
    words[addr[9:2]] = value;
  endtask

  // ====================
  // Bus responder
  // ====================
  initial begin
    seed = 32'h1cb;
    void'($urandom(seed));
    instr_ack = 1'b0;
    instr_data = '0;
    data_ack = 1'b0;
    data_rd_data = '0;
    instr_wait = 0;
    data_wait = 0;
    store_count = 0;
    forever begin
      @(negedge clk);
      if (reset) begin
        instr_ack = 1'b0;
        data_ack = 1'b0;
        instr_wait = next_delay();
        data_wait = next_delay();
        store_count = 0;
      end else begin
        // Ack lasts one cycle, then a fresh delay for the next request
        if (instr_ack) begin
          instr_ack = 1'b0;
          instr_wait = next_delay();
        end else if (instr_req) begin
          if (instr_wait == 0) begin
            instr_ack = 1'b1;
            instr_data = words[instr_addr[9:2]];
          end else begin
            instr_wait--;
          end
        end
        if (data_ack) begin
          data_ack = 1'b0;
          data_wait = next_delay();
        end else if (data_req) begin
          if (data_wait == 0) begin
            data_ack = 1'b1;
            if (data_wr_en) begin
              words[data_addr[9:2]] = data_wr_data;
              if (store_count < MAX_STORES) begin
                store_addr[store_count] = data_addr;
                store_data[store_count] = data_wr_data;
              end
              store_count++;
            end else begin
              data_rd_data = words[data_addr[9:2]];
            end
          end else begin
            data_wait--;
          end
        end
      end
    end
  end

endmodule

// File: sim/tb_kronos_core.sv
// Directed tests for the Kronos core with hand-assembled programs.
// Checks the store sequence on the data bus against expected values.
`include "kronos_macros.svh"

module tb_kronos_core;
  timeunit 1ns;
  timeprecision 1ps;
  import kronos_types::*;

  localparam word_t BOOT          = `KRONOS_BOOT_ADDR;
  localparam word_t HALT          = 32'h0000_006f;
  localparam int    DATA_BASE     = 'h200;
  localparam int    LOAD_BASE     = 'h300;
  localparam int    STORE_TIMEOUT = 400;
  localparam int    REQ_TIMEOUT   = 20;
  localparam int    QUIET_CYCLES  = 40;

  localparam int OP_LUI   = 'h37;
  localparam int OP_AUIPC = 'h17;
  localparam int OP_JALR  = 'h67;
  localparam int OP_LOAD  = 'h03;
  localparam int OP_IMM   = 'h13;

  logic  clk;
  logic  reset;
  logic  rand_delay;
  word_t instr_addr, instr_data, data_addr, data_wr_data, data_rd_data;
  logic  instr_req, instr_ack, data_wr_en, data_req, data_ack;

  word_t prog_pc;
  int    store_off;
  int    marker;
  word_t reg_value [4];
  word_t exp_addr [$];
  word_t exp_data [$];

  kronos_core #(
    .BOOT_ADDR(BOOT)
  ) dut (
    .clk, .reset,
    .instr_addr, .instr_req, .instr_data, .instr_ack,
    .data_addr, .data_wr_data, .data_wr_en, .data_req,
    .data_rd_data, .data_ack
  );

  kronos_mem_model mem (
    .clk, .reset, .rand_delay,
    .instr_addr, .instr_req, .instr_data, .instr_ack,
    .data_addr, .data_wr_data, .data_wr_en, .data_req,
    .data_rd_data, .data_ack
  );

  always #2 clk = ~clk;

  // ====================
  // Instruction encoding
  // ====================
  function automatic word_t rtype(input int f7, input int rs2, input int rs1,
                                  input int f3, input int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
  endfunction

  function automatic word_t itype(input int imm, input int rs1, input int f3,
                                  input int rd, input int op);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
  endfunction

  function automatic word_t stype(input int imm, input int rs2, input int rs1);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'h23};
  endfunction

  function automatic word_t btype(input int imm, input int rs2, input int rs1, input int f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic word_t utype(input int imm, input int rd, input int op);
    return {imm[19:0], rd[4:0], op[6:0]};
  endfunction

  function automatic word_t jtype(input int imm, input int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
  endfunction

  // ====================
  // Reference arithmetic
  // ====================
  function automatic bit lt_signed(input word_t a, input word_t b);
    if (a[31] != b[31]) return a[31];
    return a < b;
  endfunction

  function automatic word_t arith_shift(input word_t a, input int sh);
    word_t fill;
    fill = a[31] ? ~(32'hffff_ffff >> sh) : 32'h0;
    return (a >> sh) | fill;
  endfunction

  function automatic bit branch_taken(input int f3, input word_t a, input word_t b);
    case (f3)
      0:       return a == b;
      1:       return a != b;
      4:       return lt_signed(a, b);
      5:       return !lt_signed(a, b);
      6:       return a < b;
      default: return a >= b;
    endcase
  endfunction

  // ====================
  // Checks
  // ====================
  task automatic abort_run();
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      $display("Fail %s: expected %h, actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Fail %s: expected %b, actual %b", name, exp, act);
      abort_run();
    end
  endtask

  // ====================
  // Program building
  // ====================
  task automatic emit(input word_t instr);
    mem.write_word(prog_pc, instr);
    prog_pc += 4;
  endtask

  // x31 holds the store area base in every program
  task automatic begin_test(input logic slow);
    @(negedge clk);
    reset = 1'b1;
    rand_delay = slow;
    mem.fill_pattern();
    exp_addr.delete();
    exp_data.delete();
    prog_pc = BOOT;
    store_off = 0;
    emit(itype(DATA_BASE, 0, 0, 31, OP_IMM));
  endtask

  task automatic load_const(input int rd, input word_t value);
    word_t hi;
    word_t lo;
    hi = (value + 32'h800) >> 12;
    lo = value - (hi << 12);
    emit(utype(int'(hi), rd, OP_LUI));
    emit(itype(int'(lo), rd, 0, rd, OP_IMM));
  endtask

  task automatic store_reg(input int rs, input word_t value, input bit expected);
    emit(stype(store_off, rs, 31));
    if (expected) begin
      exp_addr.push_back(word_t'(DATA_BASE + store_off));
      exp_data.push_back(value);
    end
    store_off += 4;
  endtask

  task automatic alu_case(input word_t instr, input word_t expected);
    emit(instr);
    store_reg(4, expected, 1'b1);
  endtask

  // Fallthrough store only shows up when the branch is not taken
  task automatic branch_case(input int f3, input int rs1, input int rs2);
    bit taken;
    taken = branch_taken(f3, reg_value[rs1], reg_value[rs2]);
    emit(btype(12, rs2, rs1, f3));
    emit(itype(marker, 0, 0, 5, OP_IMM));
    store_reg(5, word_t'(marker), !taken);
    emit(itype(marker + 1, 0, 0, 5, OP_IMM));
    store_reg(5, word_t'(marker + 1), 1'b1);
    marker += 16;
  endtask

  task automatic wait_for_store(input string name, input int idx);
    int cycles;
    cycles = 0;
    while (mem.store_count <= idx) begin
      @(posedge clk);
      cycles++;
      if (cycles > STORE_TIMEOUT) begin
        $display("Timeout in %s: store %0d never arrived on the data bus", name, idx);
        abort_run();
      end
    end
  endtask

  task automatic run_program(input string name);
    repeat (8) @(negedge clk);
    reset = 1'b0;
    for (int i = 0; i < exp_addr.size(); i++) begin
      wait_for_store(name, i);
      check_word($sformatf("%s store %0d address", name, i), exp_addr[i], mem.store_addr[i]);
      check_word($sformatf("%s store %0d data", name, i), exp_data[i], mem.store_data[i]);
    end
    // Nothing more may reach the bus once the program halts
    repeat (QUIET_CYCLES) @(posedge clk);
    check_word({name, " store count"}, word_t'(exp_addr.size()), word_t'(mem.store_count));
  endtask

  // ====================
  // Tests
  // ====================
  task automatic test_reset();
    string name;
    int    cycles;
    name = "reset";
    begin_test(1'b0);
    emit(HALT);
    for (int i = 0; i < 8; i++) begin
      @(negedge clk);
      check_bit({name, " instr_req"}, 1'b0, instr_req);
      check_bit({name, " data_req"}, 1'b0, data_req);
      check_bit({name, " data_wr_en"}, 1'b0, data_wr_en);
    end
    reset = 1'b0;
    check_bit({name, " instr_req after"}, 1'b0, instr_req);
    check_bit({name, " data_req after"}, 1'b0, data_req);
    check_bit({name, " data_wr_en after"}, 1'b0, data_wr_en);
    cycles = 0;
    while (!instr_req) begin
      @(negedge clk);
      cycles++;
      if (cycles > REQ_TIMEOUT) begin
        $display("Timeout in %s: first instruction request never arrived", name);
        abort_run();
      end
    end
    check_word({name, " boot address"}, BOOT, instr_addr);
  endtask

  task automatic test_alu(input string name, input logic slow);
    word_t a;
    word_t b;
    int    sh;
    a = 32'h1234_5678;
    b = 32'hfedc_b987;
    sh = 7;
    begin_test(slow);
    load_const(1, a);
    load_const(2, b);
    emit(itype(sh, 0, 0, 3, OP_IMM));
    // Register forms, result in x4 and stored right away
    alu_case(rtype(0, 2, 1, 0, 4), a + b);
    alu_case(rtype('h20, 2, 1, 0, 4), a - b);
    alu_case(rtype(0, 3, 2, 1, 4), b << sh);
    alu_case(rtype(0, 1, 2, 2, 4), word_t'(lt_signed(b, a)));
    alu_case(rtype(0, 2, 1, 3, 4), word_t'(a < b));
    alu_case(rtype(0, 2, 1, 4, 4), a ^ b);
    alu_case(rtype(0, 3, 2, 5, 4), b >> sh);
    alu_case(rtype('h20, 3, 2, 5, 4), arith_shift(b, sh));
    alu_case(rtype(0, 2, 1, 6, 4), a | b);
    alu_case(rtype(0, 2, 1, 7, 4), a & b);
    // Immediate forms
    alu_case(itype(-5, 1, 0, 4, OP_IMM), a - 32'd5);
    alu_case(itype(4, 1, 1, 4, OP_IMM), a << 4);
    alu_case(itype(-1, 2, 2, 4, OP_IMM), word_t'(lt_signed(b, 32'hffff_ffff)));
    alu_case(itype('h7ff, 1, 3, 4, OP_IMM), word_t'(a < 32'h7ff));
    alu_case(itype('h555, 2, 4, 4, OP_IMM), b ^ 32'h555);
    alu_case(itype(12, 2, 5, 4, OP_IMM), b >> 12);
    alu_case(itype('h40c, 2, 5, 4, OP_IMM), arith_shift(b, 12));
    alu_case(itype(-256, 1, 6, 4, OP_IMM), a | 32'hffff_ff00);
    alu_case(itype('h0f0, 2, 7, 4, OP_IMM), b & 32'h0f0);
    emit(HALT);
    run_program(name);
  endtask

  task automatic test_branches();
    begin_test(1'b0);
    reg_value[1] = 32'd5;
    reg_value[2] = 32'hffff_fffd;
    reg_value[3] = 32'd5;
    marker = 1;
    emit(itype(5, 0, 0, 1, OP_IMM));
    emit(itype(-3, 0, 0, 2, OP_IMM));
    emit(itype(5, 0, 0, 3, OP_IMM));
    // Each kind once with a taken pair and once with a not-taken pair
    branch_case(0, 1, 3);
    branch_case(0, 1, 2);
    branch_case(1, 1, 2);
    branch_case(1, 1, 3);
    branch_case(4, 2, 1);
    branch_case(4, 1, 2);
    branch_case(5, 1, 2);
    branch_case(5, 2, 1);
    branch_case(6, 1, 2);
    branch_case(6, 2, 1);
    branch_case(7, 2, 1);
    branch_case(7, 1, 2);
    emit(HALT);
    run_program("branches");
  endtask

  task automatic test_jumps();
    word_t jal_pc;
    word_t auipc_pc;
    begin_test(1'b0);
    jal_pc = prog_pc;
    emit(jtype(12, 1));
    emit(itype('h3c3, 0, 0, 5, OP_IMM));
    store_reg(5, 32'h3c3, 1'b0);
    store_reg(1, jal_pc + 32'd4, 1'b1);
    // Odd offset, the target drops bit 0
    auipc_pc = prog_pc;
    emit(utype(0, 6, OP_AUIPC));
    emit(itype(17, 6, 0, 7, OP_JALR));
    emit(itype('h3c3, 0, 0, 5, OP_IMM));
    store_reg(5, 32'h3c3, 1'b0);
    store_reg(7, auipc_pc + 32'd8, 1'b1);
    store_reg(6, auipc_pc, 1'b1);
    emit(HALT);
    run_program("jumps");
  endtask

  task automatic test_loads(input string name, input logic slow);
    word_t d [4];
    d[0] = 32'h0123_4567;
    d[1] = 32'h89ab_cdef;
    d[2] = 32'h7fff_fffe;
    d[3] = 32'hcafe_f00d;
    begin_test(slow);
    for (int i = 0; i < 4; i++) begin
      mem.write_word(word_t'(LOAD_BASE + 4 * i), d[i]);
    end
    emit(itype(LOAD_BASE, 0, 0, 30, OP_IMM));
    emit(itype(0, 30, 2, 1, OP_LOAD));
    emit(itype(4, 30, 2, 2, OP_LOAD));
    emit(rtype(0, 2, 1, 0, 3));
    store_reg(3, d[0] + d[1], 1'b1);
    emit(itype(8, 30, 2, 4, OP_LOAD));
    emit(rtype(0, 3, 4, 0, 5));
    store_reg(5, d[2] + d[0] + d[1], 1'b1);
    // Load feeding a store directly
    emit(itype(12, 30, 2, 6, OP_LOAD));
    store_reg(6, d[3], 1'b1);
    emit(HALT);
    run_program(name);
  endtask

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    rand_delay = 1'b0;
    test_reset();
    test_alu("alu", 1'b0);
    test_branches();
    test_jumps();
    test_loads("loads", 1'b0);
    test_alu("alu_backpressure", 1'b1);
    test_loads("loads_backpressure", 1'b1);
    $display("All tests passed!");
    $finish;
  end

endmodule

// File: filelist.f
+incdir+hdl
hdl/kronos_types.sv
hdl/kronos_rf.sv
hdl/kronos_if.sv
hdl/kronos_id.sv
hdl/kronos_ex.sv
hdl/kronos_core.sv
sim/kronos_mem_model.sv
sim/tb_kronos_core.sv

// File: Bender.yml
package:
  name: kronos_core

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/kronos_types.sv
      - hdl/kronos_rf.sv
      - hdl/kronos_if.sv
      - hdl/kronos_id.sv
      - hdl/kronos_ex.sv
      - hdl/kronos_core.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - sim/kronos_mem_model.sv
      - sim/tb_kronos_core.sv
